// File: filelist.f
sync_long_pkg.sv
buf_rd_if.sv
sample_buffer.sv
lts_correlator.sv
sync_long_counter.sv
sync_long_fsm.sv
sync_long_top.sv
sync_long_checker.sv
tb_sync_long.sv

// File: Makefile
SIM  := obj_dir/Vtb_sync_long
SRCS := $(shell grep -v '^+' filelist.f)

.PHONY: all run clean

all: run

$(SIM): filelist.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_sync_long -Mdir obj_dir -f filelist.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_sync_long.sv
`timescale 1ns/1ps

module tb_sync_long;

    localparam int SKIP_LEN    = sync_long_pkg::STS_TAIL + sync_long_pkg::CP_SKIP;
    localparam int SRCH_LEN    = sync_long_pkg::PEAK_SEARCH_LEN;
    localparam int SYM_LEN     = sync_long_pkg::SYMBOL_LEN;
    localparam int NUM_SYM     = 6;
    localparam int WIN_TOTAL   = NUM_SYM * SYM_LEN;
    localparam int MAX_STROBES = 2 * (SKIP_LEN + 512);    // upper bound over both packets

    logic        clock = 1'b0;
    logic        reset;
    logic [31:0] sample_i;
    logic        sample_valid_i;
    logic        short_gi_i;
    logic [3:0]  win_shift_i;
    logic [31:0] metric_o;
    logic        metric_valid_o;
    logic        preamble_detected_o;
    logic [31:0] sample_o;
    logic        sample_valid_o;
    logic        symbol_last_o;
    logic [15:0] num_symbol_o;

    logic [31:0] post_q [$];        // samples from index 0 on
    logic [31:0] exp_win [$];
    logic [31:0] exp_metric [SRCH_LEN];
    int          strobe_cyc [SRCH_LEN];
    int          err [4];
    int          cyc = 0;
    int          metric_seen = 0;
    int          det_seen = 0;
    int          win_seen = 0;
    int          last_metric_cyc = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          checks = 0;
    bit          active = 1'b0;
    bit          in_skip = 1'b0;

    sync_long_top i_dut (
        .clock               (clock),
        .reset               (reset),
        .sample_i            (sample_i),
        .sample_valid_i      (sample_valid_i),
        .short_gi_i          (short_gi_i),
        .win_shift_i         (win_shift_i),
        .metric_o            (metric_o),
        .metric_valid_o      (metric_valid_o),
        .preamble_detected_o (preamble_detected_o),
        .sample_o            (sample_o),
        .sample_valid_o      (sample_valid_o),
        .symbol_last_o       (symbol_last_o),
        .num_symbol_o        (num_symbol_o)
    );

    always #2 clock = ~clock;
    always @(posedge clock) cyc <= cyc + 1;

    function automatic logic [31:0] pack_iq(int i, int q);
        logic [15:0] hi;
        logic [15:0] lo;
        hi = 16'(i);
        lo = 16'(q);
        return {hi, lo};
    endfunction

    function automatic int small_comp(int lim);
        return int'($urandom_range(32'(2 * lim))) - lim;
    endfunction

    // cross-correlation of samples n-31..n against the conjugated reference
    function automatic logic [31:0] ref_metric(int n);
        longint      acc_i;
        longint      acc_q;
        longint      mag;
        longint      wi;
        longint      wq;
        longint      ci;
        longint      cq;
        logic [31:0] w;
        logic [31:0] c;
        acc_i = 0;
        acc_q = 0;
        for (int k = 0; k < sync_long_pkg::LTS_LEN; k++) begin
            if (n - (sync_long_pkg::LTS_LEN - 1) + k >= 0) begin
                w  = post_q[n - (sync_long_pkg::LTS_LEN - 1) + k];
                c  = sync_long_pkg::lts_coeff[k];
                wi = longint'($signed(w[31:16]));
                wq = longint'($signed(w[15:0]));
                ci = longint'($signed(c[31:16]));
                cq = longint'($signed(c[15:0]));
                acc_i += wi * ci + wq * cq;
                acc_q += wq * ci - wi * cq;
            end
        end
        mag = (acc_i < 0 ? -acc_i : acc_i) + (acc_q < 0 ? -acc_q : acc_q);
        return (mag > 64'hFFFF_FFFF) ? 32'hFFFF_FFFF : 32'(mag);
    endfunction

    function automatic int win_begin(int s, int k, int g);
        if (k < 2) begin
            return s + k * SYM_LEN;     // training symbols back to back
        end
        return s + 2 * SYM_LEN + (k - 2) * (SYM_LEN + g) + g;
    endfunction

    task automatic check_hex(int cat, string name, logic [31:0] got, logic [31:0] expv);
        checks++;
        assert (got === expv) else begin
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, expv);
            err[cat]++;
        end
    endtask

    task automatic check_true(int cat, bit cond, string what);
        checks++;
        assert (cond) else begin
            $display("error: %s", what);
            err[cat]++;
        end
    endtask

    task automatic report_test(string name, int errs);
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %-36s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    // one strobe, then a random gap of 6 to 9 cycles
    task automatic send_sample(logic [31:0] s, int idx);
        int gap;
        gap = 6 + int'($urandom_range(3));
        @(posedge clock);
        #1;
        sample_i       = s;
        sample_valid_i = 1'b1;
        if (idx >= 0 && idx < SRCH_LEN) begin
            strobe_cyc[idx] = cyc;
        end
        @(posedge clock);
        #1;
        sample_valid_i = 1'b0;
        repeat (gap - 2) @(posedge clock);
    endtask

    // output monitor, sampled away from the edges
    always @(negedge clock) begin
        if (active) begin
            if (in_skip) begin
                check_true(0, !(metric_valid_o || sample_valid_o || preamble_detected_o),
                           "output active while short preamble tail and CP are skipped");
            end
            if (metric_valid_o) begin
                if (metric_seen < SRCH_LEN) begin
                    check_hex(1, "metric_o", metric_o, exp_metric[metric_seen]);
                    check_true(1, cyc - strobe_cyc[metric_seen] == 6,
                               "metric_valid_o not 6 cycles after its strobe");
                    last_metric_cyc = cyc;
                end else begin
                    check_true(1, 1'b0, "metric appeared after the 64 of the peak search");
                end
                metric_seen++;
            end
            if (preamble_detected_o) begin
                check_true(2, det_seen == 0 && metric_seen == SRCH_LEN
                           && cyc == last_metric_cyc + 1,
                           "preamble detect not a single pulse right after the 64th metric");
                det_seen++;
            end
            if (sample_valid_o) begin
                if (det_seen == 0) begin
                    check_true(3, 1'b0, "window sample came before preamble detect");
                end else if (win_seen < WIN_TOTAL) begin
                    check_hex(3, "sample_o", sample_o, exp_win[win_seen]);
                    check_hex(3, "symbol_last_o", 32'(symbol_last_o),
                              32'(win_seen % SYM_LEN == SYM_LEN - 1));
                    check_hex(3, "num_symbol_o", 32'(num_symbol_o), 32'(win_seen / SYM_LEN));
                end else begin
                    check_true(3, 1'b0, "window sample beyond the six expected symbols");
                end
                win_seen++;
            end
        end
    end

    task automatic run_packet(int pkt, bit short_gi, logic [3:0] shift);
        int          p;
        int          g;
        int          s;
        int          peak;
        int          n_post;
        logic [31:0] best;
        logic [31:0] c;
        active         = 1'b0;
        reset          = 1'b1;
        sample_valid_i = 1'b0;
        short_gi_i     = short_gi;
        win_shift_i    = shift;
        for (int i = 0; i < 4; i++) begin
            err[i] = 0;
        end
        metric_seen = 0;
        det_seen    = 0;
        win_seen    = 0;
        post_q.delete();
        exp_win.delete();

        // LTS placed at index p, noise elsewhere
        p = 24 + int'($urandom_range(7));
        g = short_gi ? sync_long_pkg::GI_SHORT : sync_long_pkg::GI_LONG;
        for (int n = 0; n < SRCH_LEN; n++) begin
            if (n >= p && n < p + sync_long_pkg::LTS_LEN) begin
                c = sync_long_pkg::lts_coeff[n - p];
                post_q.push_back(c);
            end else begin
                post_q.push_back(pack_iq(small_comp(31), small_comp(31)));
            end
        end
        best = '0;
        peak = 0;
        for (int n = 0; n < SRCH_LEN; n++) begin
            exp_metric[n] = ref_metric(n);
            if (n < SRCH_LEN - 1 && exp_metric[n] > best) begin
                best = exp_metric[n];   // first of equal maxima wins
                peak = n;
            end
        end
        s = (((peak - (sync_long_pkg::LTS_LEN - 1) - int'(shift)) % 256) + 256) % 256;
        n_post = win_begin(s, NUM_SYM - 1, g) + SYM_LEN + 4;
        while (post_q.size() < n_post) begin
            post_q.push_back(pack_iq(small_comp(31), small_comp(31)));
        end
        for (int k = 0; k < NUM_SYM; k++) begin
            for (int j = 0; j < SYM_LEN; j++) begin
                exp_win.push_back(post_q[win_begin(s, k, g) + j]);
            end
        end

        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        check_hex(0, "metric_valid_o", 32'(metric_valid_o), 32'd0);
        check_hex(0, "sample_valid_o", 32'(sample_valid_o), 32'd0);
        check_hex(0, "preamble_detected_o", 32'(preamble_detected_o), 32'd0);
        check_hex(0, "num_symbol_o", 32'(num_symbol_o), 32'd0);
        active  = 1'b1;
        in_skip = 1'b1;
        for (int i = 0; i < SKIP_LEN; i++) begin
            send_sample(pack_iq(small_comp(255), small_comp(255)), -1);
        end
        in_skip = 1'b0;
        for (int n = 0; n < n_post; n++) begin
            send_sample(post_q[n], n);
        end
        while (win_seen < WIN_TOTAL) @(posedge clock);
        repeat (200) @(posedge clock);      // nothing more may follow
        #1;
        check_true(1, metric_seen == SRCH_LEN, "metric count differs from 64");
        check_true(2, det_seen == 1, "preamble detect count differs from one");
        check_true(3, win_seen == WIN_TOTAL, "window sample count differs from six symbols");
        active = 1'b0;

        report_test($sformatf("packet %0d skip quiet", pkt), err[0]);
        report_test($sformatf("packet %0d metrics", pkt), err[1]);
        report_test($sformatf("packet %0d preamble detect", pkt), err[2]);
        report_test($sformatf("packet %0d windows gi %0d shift %0d", pkt, g, shift), err[3]);
    endtask

    initial begin
        int shift1;
        int shift2;
        void'($urandom(32'h5239b5f4));
        reset          = 1'b1;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        short_gi_i     = 1'b0;
        win_shift_i    = '0;
        shift1 = int'($urandom_range(15));
        shift2 = (shift1 + 1 + int'($urandom_range(14))) % 16;
        run_packet(1, 1'b0, 4'(shift1));
        run_packet(2, 1'b1, 4'(shift2));
        $display("tests %0d, passed %0d, failed %0d, checks %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, checks,
                 i_dut.i_checker.fail_count);
        if (tests_failed == 0 && i_dut.i_checker.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (MAX_STROBES * 10 + 2000) @(posedge clock);
        $display("timeout: run did not finish within the time of %0d strobes", MAX_STROBES);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: sync_long_checker.sv
`timescale 1ns/1ps

module sync_long_checker (
    input logic clock,
    input logic reset,
    input logic sample_valid_i,
    input logic symbol_last_i,
    input logic preamble_detected_i
);

    logic [6:0] run_len;    // valid cycles since the last symbol end
    int         fail_count = 0;

    always_ff @(posedge clock) begin
        if (reset) begin
            run_len <= '0;
        end else if (sample_valid_i) begin
            run_len <= symbol_last_i ? '0 : run_len + 1'b1;
        end else begin
            run_len <= '0;
        end
    end

    last_has_valid: assert property (@(posedge clock) disable iff (reset)
        symbol_last_i |-> sample_valid_i)
        else begin
            $error("symbol_last_o seen without sample_valid_o");
            fail_count++;
        end

    detect_one_cycle: assert property (@(posedge clock) disable iff (reset)
        preamble_detected_i |=> !preamble_detected_i)
        else begin
            $error("preamble_detected_o held longer than one cycle");
            fail_count++;
        end

    // a window runs 64 cycles without a hole
    valid_no_gap: assert property (@(posedge clock) disable iff (reset)
        sample_valid_i && !symbol_last_i |=> sample_valid_i)
        else begin
            $error("sample_valid_o dropped inside a symbol window");
            fail_count++;
        end

    run_complete: assert property (@(posedge clock) disable iff (reset)
        symbol_last_i |-> run_len == 7'd63)
        else begin
            $error("symbol_last_o did not end a run of 64 valid samples");
            fail_count++;
        end

endmodule

bind sync_long_top sync_long_checker i_checker (
    .clock               (clock),
    .reset               (reset),
    .sample_valid_i      (sample_valid_o),
    .symbol_last_i       (symbol_last_o),
    .preamble_detected_i (preamble_detected_o)
);

// File: sync_long_top.sv
`timescale 1ns/1ps

module sync_long_top #(
    parameter int BUF_AW = 8
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [sync_long_pkg::SAMPLE_W-1:0] sample_i,
    input  logic                               sample_valid_i,
    input  logic                               short_gi_i,
    input  logic [3:0]                         win_shift_i,
    output logic [sync_long_pkg::METRIC_W-1:0] metric_o,
    output logic                               metric_valid_o,
    output logic                               preamble_detected_o,
    output logic [sync_long_pkg::SAMPLE_W-1:0] sample_o,
    output logic                               sample_valid_o,
    output logic                               symbol_last_o,
    output logic [15:0]                        num_symbol_o
);

    sync_long_pkg::sample_t sample_in;
    logic                   corr_en;
    logic                   wr_en;
    logic                   count_cmd;
    logic                   count_clear;
    logic                   offset_step;
    logic                   symbol_step;
    logic [7:0]             count;
    logic [5:0]             offset;

    buf_rd_if #(.BUF_AW(BUF_AW)) rd_bus ();

    assign sample_in.raw = sample_i;
    assign sample_o      = rd_bus.rd_data.raw;

    sample_buffer #(.BUF_AW(BUF_AW)) u_buffer (
        .clock    (clock),
        .reset    (reset),
        .sample_i (sample_in),
        .wr_en_i  (wr_en),
        .rd       (rd_bus.buffer)
    );

    lts_correlator u_correlator (
        .clock          (clock),
        .reset          (reset),
        .sample_i       (sample_in),
        .sample_valid_i (sample_valid_i),
        .corr_en_i      (corr_en),
        .metric_o       (metric_o),
        .metric_valid_o (metric_valid_o)
    );

    sync_long_counter u_counter (
        .clock         (clock),
        .reset         (reset),
        .count_i       (count_cmd),
        .count_clear_i (count_clear),
        .offset_step_i (offset_step),
        .symbol_step_i (symbol_step),
        .count_o       (count),
        .offset_o      (offset),
        .symbol_o      (num_symbol_o)
    );

    sync_long_fsm #(.BUF_AW(BUF_AW)) u_fsm (
        .clock               (clock),
        .reset               (reset),
        .sample_valid_i      (sample_valid_i),
        .short_gi_i          (short_gi_i),
        .win_shift_i         (win_shift_i),
        .metric_i            (metric_o),
        .metric_valid_i      (metric_valid_o),
        .count_i             (count),
        .offset_i            (offset),
        .symbol_i            (num_symbol_o),
        .count_o             (count_cmd),
        .count_clear_o       (count_clear),
        .offset_step_o       (offset_step),
        .symbol_step_o       (symbol_step),
        .corr_en_o           (corr_en),
        .wr_en_o             (wr_en),
        .preamble_detected_o (preamble_detected_o),
        .sample_valid_o      (sample_valid_o),
        .symbol_last_o       (symbol_last_o),
        .rd                  (rd_bus.fsm)
    );

endmodule

// File: sync_long_fsm.sv
`timescale 1ns/1ps

module sync_long_fsm #(
    parameter int BUF_AW = 8
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               sample_valid_i,
    input  logic                               short_gi_i,
    input  logic [3:0]                         win_shift_i,
    input  logic [sync_long_pkg::METRIC_W-1:0] metric_i,
    input  logic                               metric_valid_i,
    input  logic [7:0]                         count_i,
    input  logic [5:0]                         offset_i,
    input  logic [15:0]                        symbol_i,
    output logic                               count_o,
    output logic                               count_clear_o,
    output logic                               offset_step_o,
    output logic                               symbol_step_o,
    output logic                               corr_en_o,
    output logic                               wr_en_o,
    output logic                               preamble_detected_o,
    output logic                               sample_valid_o,
    output logic                               symbol_last_o,
    buf_rd_if.fsm                              rd
);

    typedef enum logic [1:0] {S_SKIP_TAIL, S_SKIP_CP, S_PEAK, S_SYMBOLS} state_t;

    state_t                             state;
    logic [sync_long_pkg::METRIC_W-1:0] metric_max;
    logic [BUF_AW:0]                    peak_idx;
    logic [BUF_AW:0]                    win_start;
    logic [BUF_AW:0]                    end_idx;    // last sample of the next window
    logic [BUF_AW:0]                    fill_diff;
    logic [BUF_AW-1:0]                  next_addr;
    logic [BUF_AW-1:0]                  gap;
    logic                               peak_done;
    logic                               win_ready;
    logic                               issue;
    logic                               issue_last;
    logic                               rd_last;
    logic                               last_q;

    assign peak_done = (state == S_PEAK) && metric_valid_i
                       && (count_i == 8'(sync_long_pkg::PEAK_SEARCH_LEN - 1));
    assign win_start = peak_idx - (BUF_AW+1)'(sync_long_pkg::LTS_LEN - 1)
                       - (BUF_AW+1)'(win_shift_i);

    // window may start once its last sample is in the buffer
    assign fill_diff  = rd.wr_count - end_idx;
    assign win_ready  = !fill_diff[BUF_AW] && (fill_diff != '0);
    assign issue      = (state == S_SYMBOLS) && ((offset_i != '0) || win_ready);
    assign issue_last = issue && (offset_i == 6'(sync_long_pkg::SYMBOL_LEN - 1));
    assign gap = (symbol_i == '0) ? '0  // both training symbols back to back
               : (short_gi_i ? BUF_AW'(sync_long_pkg::GI_SHORT) : BUF_AW'(sync_long_pkg::GI_LONG));

    always_comb begin
        case (state)
            S_SKIP_TAIL, S_SKIP_CP: count_o = sample_valid_i;
            S_PEAK:                 count_o = metric_valid_i;
            default:                count_o = 1'b0;
        endcase
    end

    assign count_clear_o = (state == S_SKIP_CP) && sample_valid_i
                           && (count_i == 8'(sync_long_pkg::STS_TAIL + sync_long_pkg::CP_SKIP - 1));
    assign corr_en_o = (state == S_PEAK)
                       && (rd.wr_count < (BUF_AW+1)'(sync_long_pkg::PEAK_SEARCH_LEN));
    assign wr_en_o        = sample_valid_i && (state == S_PEAK || state == S_SYMBOLS);
    assign offset_step_o  = issue;
    assign symbol_step_o  = symbol_last_o;      // advance once the last sample is out
    assign sample_valid_o = rd.rd_valid;
    assign symbol_last_o  = last_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state               <= S_SKIP_TAIL;
            metric_max          <= '0;
            peak_idx            <= '0;
            preamble_detected_o <= 1'b0;
            rd.rd_en            <= 1'b0;
            rd_last             <= 1'b0;
            last_q              <= 1'b0;
        end else begin
            preamble_detected_o <= peak_done;
            rd.rd_en            <= issue;
            rd_last             <= issue_last;
            last_q              <= rd.rd_en && rd_last;
            case (state)
                S_SKIP_TAIL: begin
                    if (sample_valid_i && count_i == 8'(sync_long_pkg::STS_TAIL - 1)) begin
                        state <= S_SKIP_CP;
                    end
                end
                S_SKIP_CP: begin
                    if (count_clear_o) begin
                        state <= S_PEAK;
                    end
                end
                S_PEAK: begin
                    // strict compare keeps the first of equal maxima
                    if (metric_valid_i && metric_i > metric_max
                        && count_i < 8'(sync_long_pkg::PEAK_SEARCH_LEN - 1)) begin
                        metric_max <= metric_i;
                        peak_idx   <= (BUF_AW+1)'(count_i);
                    end
                    if (peak_done) begin
                        state <= S_SYMBOLS;
                    end
                end
                default: ;  // windowing runs until reset
            endcase
        end
    end

    // read address generation
    always_ff @(posedge clock) begin
        if (peak_done) begin
            next_addr <= win_start[BUF_AW-1:0];
            end_idx   <= win_start + (BUF_AW+1)'(sync_long_pkg::SYMBOL_LEN - 1);
        end else if (issue_last) begin
            next_addr <= next_addr + 1'b1 + gap;
            end_idx   <= end_idx + (BUF_AW+1)'(sync_long_pkg::SYMBOL_LEN) + {1'b0, gap};
        end else if (issue) begin
            next_addr <= next_addr + 1'b1;
        end
        if (issue) begin
            rd.rd_addr <= next_addr;
        end
    end

endmodule

// File: sync_long_counter.sv
`timescale 1ns/1ps

module sync_long_counter (
    input  logic        clock,
    input  logic        reset,
    input  logic        count_i,
    input  logic        count_clear_i,
    input  logic        offset_step_i,
    input  logic        symbol_step_i,
    output logic [7:0]  count_o,
    output logic [5:0]  offset_o,
    output logic [15:0] symbol_o
);

    // skipped samples, then metric index
    always_ff @(posedge clock) begin
        if (reset || count_clear_i) begin
            count_o <= '0;
        end else if (count_i) begin
            count_o <= count_o + 1'b1;
        end
    end

    // position inside the 64-sample window, wraps by itself
    always_ff @(posedge clock) begin
        if (reset) begin
            offset_o <= '0;
        end else if (offset_step_i) begin
            offset_o <= offset_o + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            symbol_o <= '0;
        end else if (symbol_step_i && symbol_o != 16'(sync_long_pkg::SYM_CNT_MAX)) begin
            symbol_o <= symbol_o + 1'b1;    // holds at max
        end
    end

endmodule

// File: lts_correlator.sv
`timescale 1ns/1ps

module lts_correlator (
    input  logic                                 clock,
    input  logic                                 reset,
    input  sync_long_pkg::sample_t               sample_i,
    input  logic                                 sample_valid_i,
    input  logic                                 corr_en_i,
    output logic [sync_long_pkg::METRIC_W-1:0]   metric_o,
    output logic                                 metric_valid_o
);

    localparam int NUM_PASSES = sync_long_pkg::LTS_LEN / sync_long_pkg::MAC_LANES;
    localparam int PASS_W     = $clog2(NUM_PASSES);
    localparam int ACC_W      = sync_long_pkg::ACC_W;
    localparam int METRIC_W   = sync_long_pkg::METRIC_W;

    sync_long_pkg::sample_t win [sync_long_pkg::LTS_LEN];  // index 0 is the oldest

    logic [PASS_W-1:0]       pass_q;
    logic                    busy_q;
    logic                    sum_done_q;
    logic signed [ACC_W-1:0] acc_i_q;
    logic signed [ACC_W-1:0] acc_q_q;
    logic signed [ACC_W-1:0] part_i;
    logic signed [ACC_W-1:0] part_q;
    logic [ACC_W-1:0]        abs_i;
    logic [ACC_W-1:0]        abs_q;
    logic [ACC_W:0]          mag;

    // eight products against the conjugated reference per pass
    always_comb begin
        part_i = '0;
        part_q = '0;
        for (int j = 0; j < sync_long_pkg::MAC_LANES; j++) begin
            sync_long_pkg::sample_t w;
            sync_long_pkg::sample_t c;
            logic signed [2*sync_long_pkg::COMP_W-1:0] p_ii;
            logic signed [2*sync_long_pkg::COMP_W-1:0] p_qq;
            logic signed [2*sync_long_pkg::COMP_W-1:0] p_qi;
            logic signed [2*sync_long_pkg::COMP_W-1:0] p_iq;
            w    = win[int'(pass_q) * sync_long_pkg::MAC_LANES + j];
            c    = sync_long_pkg::lts_coeff[int'(pass_q) * sync_long_pkg::MAC_LANES + j];
            p_ii = w.iq.i * c.iq.i;
            p_qq = w.iq.q * c.iq.q;
            p_qi = w.iq.q * c.iq.i;
            p_iq = w.iq.i * c.iq.q;
            part_i = part_i + p_ii + p_qq;      // re{w * conj(c)}
            part_q = part_q + p_qi - p_iq;      // im{w * conj(c)}
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < sync_long_pkg::LTS_LEN; k++) begin
                win[k] <= '0;
            end
            pass_q         <= '0;
            busy_q         <= 1'b0;
            sum_done_q     <= 1'b0;
            metric_valid_o <= 1'b0;
        end else begin
            sum_done_q     <= 1'b0;
            metric_valid_o <= sum_done_q;
            if (sample_valid_i && corr_en_i) begin
                for (int k = 0; k < sync_long_pkg::LTS_LEN - 1; k++) begin
                    win[k] <= win[k+1];
                end
                win[sync_long_pkg::LTS_LEN-1] <= sample_i;
                pass_q <= '0;
                busy_q <= 1'b1;
            end else if (busy_q) begin
                pass_q <= pass_q + 1'b1;
                if (pass_q == PASS_W'(NUM_PASSES - 1)) begin
                    busy_q     <= 1'b0;
                    sum_done_q <= 1'b1;
                end
            end
        end
    end

    // accumulator restarts with every shifted sample
    always_ff @(posedge clock) begin
        if (sample_valid_i && corr_en_i) begin
            acc_i_q <= '0;
            acc_q_q <= '0;
        end else if (busy_q) begin
            acc_i_q <= acc_i_q + part_i;
            acc_q_q <= acc_q_q + part_q;
        end
    end

    assign abs_i = acc_i_q[ACC_W-1] ? ACC_W'(-acc_i_q) : ACC_W'(acc_i_q);
    assign abs_q = acc_q_q[ACC_W-1] ? ACC_W'(-acc_q_q) : ACC_W'(acc_q_q);
    assign mag   = {1'b0, abs_i} + {1'b0, abs_q};

    always_ff @(posedge clock) begin
        if (sum_done_q) begin
            metric_o <= (|mag[ACC_W:METRIC_W]) ? '1 : mag[METRIC_W-1:0];  // saturate
        end
    end

endmodule

// File: sample_buffer.sv
`timescale 1ns/1ps

module sample_buffer #(
    parameter int BUF_AW = 8
) (
    input  logic                   clock,
    input  logic                   reset,
    input  sync_long_pkg::sample_t sample_i,
    input  logic                   wr_en_i,
    buf_rd_if.buffer               rd
);

    localparam int DEPTH = 2 ** BUF_AW;

    logic [sync_long_pkg::SAMPLE_W-1:0] mem [DEPTH];  // stored as raw words
    logic [BUF_AW-1:0]                  wr_ptr;

    // ring storage and registered read port
    always_ff @(posedge clock) begin
        if (wr_en_i) begin
            mem[wr_ptr] <= sample_i.raw;
        end
        if (rd.rd_en) begin
            rd.rd_data.raw <= mem[rd.rd_addr];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd.wr_count <= '0;
            rd.rd_valid <= 1'b0;
        end else begin
            rd.rd_valid <= rd.rd_en;
            if (wr_en_i) begin
                wr_ptr      <= wr_ptr + 1'b1;       // wraps around the ring
                rd.wr_count <= rd.wr_count + 1'b1;
            end
        end
    end

endmodule

// File: buf_rd_if.sv
`timescale 1ns/1ps

interface buf_rd_if #(
    parameter int BUF_AW = 8
);

    logic                   rd_en;
    logic [BUF_AW-1:0]      rd_addr;
    sync_long_pkg::sample_t rd_data;
    logic                   rd_valid;   // rd_en one cycle late
    logic [BUF_AW:0]        wr_count;   // wraps, compared modulo 2**(BUF_AW+1)

    modport fsm (
        output rd_en, rd_addr,
        input  rd_valid, wr_count
    );

    modport buffer (
        input  rd_en, rd_addr,
        output rd_data, rd_valid, wr_count
    );

endinterface

// File: sync_long_pkg.sv
package sync_long_pkg;

    parameter int SAMPLE_W = 32;
    parameter int COMP_W   = 16;
    parameter int ACC_W    = 40;    // holds 32 summed complex products
    parameter int METRIC_W = 32;

    parameter int LTS_LEN   = 32;
    parameter int MAC_LANES = 8;
    parameter int SYMBOL_LEN = 64;

    parameter int STS_TAIL        = 32;
    parameter int CP_SKIP         = 22;
    parameter int PEAK_SEARCH_LEN = 64;

    parameter int GI_LONG  = 16;
    parameter int GI_SHORT = 8;

    parameter int SYM_CNT_MAX = 32767;

    // i in the upper half, q in the lower half
    typedef struct packed {
        logic signed [COMP_W-1:0] i;
        logic signed [COMP_W-1:0] q;
    } iq_t;

    typedef union packed {
        logic [SAMPLE_W-1:0] raw;
        iq_t                 iq;
    } sample_t;

    // first half of the long training symbol, time domain
    parameter sample_t lts_coeff [LTS_LEN] = '{
        {16'sd156, 16'sd0},     {-16'sd5, 16'sd120},
        {16'sd40, 16'sd111},    {16'sd97, -16'sd83},
        {16'sd21, -16'sd28},    {16'sd60, 16'sd88},
        {-16'sd115, 16'sd55},   {-16'sd38, 16'sd106},
        {16'sd98, 16'sd26},     {16'sd53, -16'sd4},
        {16'sd1, 16'sd115},     {-16'sd137, 16'sd47},
        {16'sd24, 16'sd59},     {16'sd59, 16'sd15},
        {-16'sd22, -16'sd161},  {16'sd119, 16'sd4},
        {16'sd62, 16'sd62},     {16'sd37, -16'sd98},
        {-16'sd57, -16'sd39},   {-16'sd131, -16'sd65},
        {16'sd82, -16'sd92},    {16'sd70, -16'sd14},
        {-16'sd60, -16'sd81},   {-16'sd56, 16'sd22},
        {-16'sd35, 16'sd151},   {-16'sd122, 16'sd17},
        {-16'sd127, 16'sd21},   {16'sd75, 16'sd74},
        {-16'sd3, -16'sd54},    {-16'sd92, -16'sd115},
        {16'sd92, -16'sd106},   {16'sd12, -16'sd98}
    };

endpackage
